//--- cpu_pkg.sv
package cpu_pkg;

    // Data path sizing
    localparam int RW        = 16;
    localparam int REGNO     = 8;
    localparam int REG_SEL_W = 3;

    typedef logic [RW-1:0]        word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    // ALU operation select
    localparam int ALU_MODE_W = 3;

    typedef enum logic [ALU_MODE_W-1:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SHL    = 3'd5,
        ALU_SHR    = 3'd6,
        ALU_PASS_R = 3'd7
    } alu_mode_t;

    // Flag vector layout
    localparam int FLAG_CNT = 5;
    localparam int FLAG_C   = 0;
    localparam int FLAG_Z   = 1;
    localparam int FLAG_N   = 2;
    localparam int FLAG_O   = 3;
    localparam int FLAG_P   = 4;

    typedef logic [FLAG_CNT-1:0] flags_t;

    // Jump condition codes
    // Upper bit marks a jump instruction, low bits pick the condition
    localparam int JUMP_CODE_W = 5;
    localparam int JUMP_EN_BIT = 4;

    typedef enum logic [JUMP_CODE_W-1:0] {
        JC_NONE   = 5'b00000,
        JC_UNCOND = 5'b10000,
        JC_CARRY  = 5'b10001,
        JC_EQUAL  = 5'b10010,
        JC_LT     = 5'b10011,
        JC_GT     = 5'b10100,
        JC_LE     = 5'b10101,
        JC_GE     = 5'b10110,
        JC_NE     = 5'b10111,
        JC_OVF    = 5'b11000,
        JC_PAR    = 5'b11001
    } jump_code_t;

    // Program counter value out of reset
    localparam word_t PC_RESET = 16'h0000;

endpackage

//--- exec_ctrl_if.sv
`timescale 1ns/100ps

interface exec_ctrl_if import cpu_pkg::*; ();

    // Register file write, already qualified by valid
    logic   rf_we;

    // Stored flags and gated carry enable for the ALU
    flags_t flags_q;
    logic   carry_en;

    // Program counter controls
    logic   pc_inc;
    logic   pc_load;

    modport ctrl (
        output rf_we,
        output flags_q,
        output carry_en,
        output pc_inc,
        output pc_load
    );

    modport rf (
        input rf_we
    );

    modport alu (
        input flags_q,
        input carry_en
    );

    modport pc (
        input pc_inc,
        input pc_load
    );

endinterface

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,

    exec_ctrl_if.rf         ctl,

    // Operand read selects
    input  reg_sel_t        i_l_sel,
    input  reg_sel_t        i_r_sel,

    // Write port
    input  reg_sel_t        i_w_sel,
    input  word_t           i_wdata,

    // Debug read port
    input  reg_sel_t        i_dbg_sel,

    output word_t           o_l_data,
    output word_t           o_r_data,
    output word_t           o_dbg_data
);

    word_t regs [REGNO];

    // Single write port, all entries clear on reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REGNO; i++) begin
                regs[i] <= '0;
            end
        end else if (ctl.rf_we) begin
            regs[i_w_sel] <= i_wdata;
        end
    end

    // Reads are combinational with no write bypass
    // A read in the write cycle sees the old contents
    assign o_l_data   = regs[i_l_sel];
    assign o_r_data   = regs[i_r_sel];
    assign o_dbg_data = regs[i_dbg_sel];

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    exec_ctrl_if.alu        ctl,

    input  word_t           i_l,
    input  word_t           i_r,
    input  alu_mode_t       i_mode,

    output word_t           o_result,
    output flags_t          o_flags
);

    logic        carry_in;
    logic [RW:0] sum_ext;
    word_t       result;
    logic        carry;
    logic        overflow;

    // Stored carry feeds ADD only when enabled
    assign carry_in = ctl.flags_q[FLAG_C] & ctl.carry_en;

    always_comb begin
        sum_ext  = '0;
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;

        case (i_mode)
            ALU_ADD: begin
                sum_ext  = {1'b0, i_l} + {1'b0, i_r} + {{RW{1'b0}}, carry_in};
                result   = sum_ext[RW-1:0];
                carry    = sum_ext[RW];
                overflow = (i_l[RW-1] == i_r[RW-1]) && (result[RW-1] != i_l[RW-1]);
            end
            ALU_SUB: begin
                // l + ~r + 1, so carry out means no borrow
                sum_ext  = {1'b0, i_l} + {1'b0, ~i_r} + {{RW{1'b0}}, 1'b1};
                result   = sum_ext[RW-1:0];
                carry    = sum_ext[RW];
                overflow = (i_l[RW-1] != i_r[RW-1]) && (result[RW-1] != i_l[RW-1]);
            end
            ALU_AND: begin
                result = i_l & i_r;
            end
            ALU_OR: begin
                result = i_l | i_r;
            end
            ALU_XOR: begin
                result = i_l ^ i_r;
            end
            ALU_SHL: begin
                // Left operand shifted by one, msb falls into carry
                result = {i_l[RW-2:0], 1'b0};
                carry  = i_l[RW-1];
            end
            ALU_SHR: begin
                // Logical shift, lsb falls into carry
                result = {1'b0, i_l[RW-1:1]};
                carry  = i_l[0];
            end
            ALU_PASS_R: begin
                result = i_r;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign o_result = result;

    always_comb begin
        o_flags         = '0;
        o_flags[FLAG_C] = carry;
        o_flags[FLAG_Z] = (result == '0);
        o_flags[FLAG_N] = result[RW-1];
        o_flags[FLAG_O] = overflow;
        // Set when the result holds an even number of ones
        o_flags[FLAG_P] = ~^result;
    end

endmodule

//--- prog_counter.sv
`timescale 1ns/100ps

module prog_counter import cpu_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,

    exec_ctrl_if.pc         ctl,

    // Jump target from the ALU result
    input  word_t           i_target,

    output word_t           o_pc
);

    word_t pc_q;

    // Load wins over increment
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= PC_RESET;
        end else if (ctl.pc_load) begin
            pc_q <= i_target;
        end else if (ctl.pc_inc) begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    assign o_pc = pc_q;

endmodule

//--- exec_control.sv
`timescale 1ns/100ps

module exec_control import cpu_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Pipeline handshake
    input  logic            i_submit,
    input  logic            i_flush,

    // Decoded controls for this instruction
    input  logic            i_pc_inc,
    input  logic            i_rf_we,
    input  logic            i_carry_en,
    input  logic            i_flags_we,
    input  logic            i_jmp_predict,
    input  jump_code_t      i_jump_code,

    // Fresh flags from the ALU
    input  flags_t          i_alu_flags,

    output logic            o_valid,
    output logic            o_flush,

    exec_ctrl_if.ctrl       ctl
);

    logic   valid;
    logic   jump_present;
    logic   jump_taken;
    logic   mispredict;
    flags_t flags_q;

    // Bubbles and flushed slots must not touch any state
    assign valid   = i_submit & ~i_flush;
    assign o_valid = valid;

    // Any code with the top bit set counts as a jump,
    // unknown conditions simply resolve as not taken
    assign jump_present = i_jump_code[JUMP_EN_BIT];

    // Conditions use the flags stored by earlier instructions
    always_comb begin
        case (i_jump_code)
            JC_UNCOND: jump_taken = 1'b1;
            JC_CARRY:  jump_taken = flags_q[FLAG_C];
            JC_EQUAL:  jump_taken = flags_q[FLAG_Z];
            JC_LT:     jump_taken = flags_q[FLAG_N];
            JC_GT:     jump_taken = ~(flags_q[FLAG_N] | flags_q[FLAG_Z]);
            JC_LE:     jump_taken = flags_q[FLAG_N] | flags_q[FLAG_Z];
            JC_GE:     jump_taken = ~flags_q[FLAG_N];
            JC_NE:     jump_taken = ~flags_q[FLAG_Z];
            JC_OVF:    jump_taken = flags_q[FLAG_O];
            JC_PAR:    jump_taken = flags_q[FLAG_P];
            default:   jump_taken = 1'b0;
        endcase
    end

    assign mispredict = valid & jump_present & (jump_taken ^ i_jmp_predict);

    // Gated controls toward the datapath
    assign ctl.rf_we    = i_rf_we & valid;
    assign ctl.carry_en = i_carry_en & valid;
    assign ctl.flags_q  = flags_q;
    assign ctl.pc_load  = valid & jump_present & jump_taken;
    assign ctl.pc_inc   = valid & (jump_present ? ~jump_taken : i_pc_inc);

    // Flags register
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            flags_q <= '0;
        end else if (valid && i_flags_we) begin
            flags_q <= i_alu_flags;
        end
    end

    // Flush goes out one cycle after the mispredicted jump
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= mispredict;
        end
    end

endmodule

//--- exec_stage.sv
`timescale 1ns/100ps

module exec_stage import cpu_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Pipeline handshake
    input  logic            i_submit,
    input  logic            i_flush,
    output logic            o_flush,

    input  word_t           i_imm,
    input  logic            i_jmp_predict,

    // Decoded instruction controls
    input  logic            i_pc_inc,
    input  logic            i_r_imm,
    input  alu_mode_t       i_alu_mode,
    input  logic            i_carry_en,
    input  logic            i_flags_we,
    input  reg_sel_t        i_l_sel,
    input  reg_sel_t        i_r_sel,
    input  reg_sel_t        i_w_sel,
    input  logic            i_rf_we,
    input  jump_code_t      i_jump_code,

    // Toward fetch
    output logic            o_pc_update,
    output word_t           o_exec_pc,

    // Debug register port
    input  reg_sel_t        i_dbg_sel,
    output word_t           o_dbg_reg
);

    word_t  l_data;
    word_t  r_data;
    word_t  alu_r;
    word_t  alu_result;
    flags_t alu_flags;
    logic   valid;

    exec_ctrl_if ctl_if ();

    exec_control u_control (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_submit      (i_submit),
        .i_flush       (i_flush),
        .i_pc_inc      (i_pc_inc),
        .i_rf_we       (i_rf_we),
        .i_carry_en    (i_carry_en),
        .i_flags_we    (i_flags_we),
        .i_jmp_predict (i_jmp_predict),
        .i_jump_code   (i_jump_code),
        .i_alu_flags   (alu_flags),
        .o_valid       (valid),
        .o_flush       (o_flush),
        .ctl           (ctl_if.ctrl)
    );

    reg_file u_rf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .ctl        (ctl_if.rf),
        .i_l_sel    (i_l_sel),
        .i_r_sel    (i_r_sel),
        .i_w_sel    (i_w_sel),
        .i_wdata    (alu_result),
        .i_dbg_sel  (i_dbg_sel),
        .o_l_data   (l_data),
        .o_r_data   (r_data),
        .o_dbg_data (o_dbg_reg)
    );

    // Right operand is either the immediate or a register
    assign alu_r = i_r_imm ? i_imm : r_data;

    alu u_alu (
        .ctl      (ctl_if.alu),
        .i_l      (l_data),
        .i_r      (alu_r),
        .i_mode   (i_alu_mode),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    // Jump target comes straight from the ALU result
    prog_counter u_pc (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .ctl      (ctl_if.pc),
        .i_target (alu_result),
        .o_pc     (o_exec_pc)
    );

    assign o_pc_update = valid;

endmodule

//--- exec_tb_model.svh
`ifndef EXEC_TB_MODEL_SVH
`define EXEC_TB_MODEL_SVH

// Mirrored architectural state
logic [15:0] m_regs [8];
logic [4:0]  m_flags;
logic [15:0] m_pc;
logic        m_flush;

task automatic clear_state();
    for (int i = 0; i < 8; i++) begin
        m_regs[i] = '0;
    end
    m_flags = '0;
    m_pc    = PC_RESET;
    m_flush = 1'b0;
endtask

function automatic logic even_parity(input logic [15:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 16; i++) begin
        ones += v[i];
    end
    return (ones % 2) == 0;
endfunction

// Signed overflow found by range check on full integers
task automatic compute_alu(input logic [15:0] l, input logic [15:0] r, input logic [2:0] mode,
                           input logic cin, output logic [15:0] res, output logic [4:0] fl);
    int sl;
    int sr;
    int ul;
    int ur;
    int wide;
    sl = $signed(l);
    sr = $signed(r);
    ul = l;
    ur = r;
    fl = '0;
    case (mode)
        ALU_ADD: begin
            res        = l + r + cin;
            wide       = sl + sr + (cin ? 1 : 0);
            fl[FLAG_C] = (ul + ur + (cin ? 1 : 0)) > 65535;
            fl[FLAG_O] = (wide > 32767) || (wide < -32768);
        end
        ALU_SUB: begin
            res        = l - r;
            wide       = sl - sr;
            fl[FLAG_C] = ul >= ur;
            fl[FLAG_O] = (wide > 32767) || (wide < -32768);
        end
        ALU_AND: res = l & r;
        ALU_OR:  res = l | r;
        ALU_XOR: res = l ^ r;
        ALU_SHL: begin
            res        = l << 1;
            fl[FLAG_C] = l[15];
        end
        ALU_SHR: begin
            res        = l >> 1;
            fl[FLAG_C] = l[0];
        end
        default: res = r;
    endcase
    fl[FLAG_Z] = (res == 16'h0000);
    fl[FLAG_N] = res[15];
    fl[FLAG_P] = even_parity(res);
endtask

function automatic logic decide_jump(input logic [4:0] code, input logic [4:0] f);
    case (code)
        JC_UNCOND: return 1'b1;
        JC_CARRY:  return f[FLAG_C];
        JC_EQUAL:  return f[FLAG_Z];
        JC_LT:     return f[FLAG_N];
        JC_GT:     return !f[FLAG_N] && !f[FLAG_Z];
        JC_LE:     return f[FLAG_N] || f[FLAG_Z];
        JC_GE:     return !f[FLAG_N];
        JC_NE:     return !f[FLAG_Z];
        JC_OVF:    return f[FLAG_O];
        JC_PAR:    return f[FLAG_P];
        default:   return 1'b0;
    endcase
endfunction

// Next state after the staged instruction reaches the clock edge
task automatic commit_instr();
    logic [15:0] r_op;
    logic [15:0] res;
    logic [4:0]  fl;
    logic        valid;
    logic        taken;
    valid = n_submit && !n_flush;
    r_op  = n_r_imm ? n_imm : m_regs[n_r_sel];
    compute_alu(m_regs[n_l_sel], r_op, n_mode, m_flags[FLAG_C] && n_carry_en, res, fl);
    taken   = decide_jump(n_jump_code, m_flags);
    m_flush = valid && n_jump_code[4] && (taken != n_predict);
    if (valid) begin
        if (n_jump_code[4]) begin
            m_pc = taken ? res : m_pc + 16'd1;
        end else if (n_pc_inc) begin
            m_pc = m_pc + 16'd1;
        end
        if (n_rf_we) begin
            m_regs[n_w_sel] = res;
        end
        if (n_flags_we) begin
            m_flags = fl;
        end
    end
endtask

`endif

//--- exec_stage_tb.sv
`timescale 1ns/100ps

module exec_stage_tb import cpu_pkg::*; ();

    logic       i_clk;
    logic       i_rst_n;
    logic       i_submit;
    logic       i_flush;
    word_t      i_imm;
    logic       i_jmp_predict;
    logic       i_pc_inc;
    logic       i_r_imm;
    alu_mode_t  i_alu_mode;
    logic       i_carry_en;
    logic       i_flags_we;
    reg_sel_t   i_l_sel;
    reg_sel_t   i_r_sel;
    reg_sel_t   i_w_sel;
    logic       i_rf_we;
    jump_code_t i_jump_code;
    reg_sel_t   i_dbg_sel;
    logic       o_flush;
    logic       o_pc_update;
    word_t      o_exec_pc;
    word_t      o_dbg_reg;

    // Next instruction, staged before it is driven
    logic        n_submit, n_flush, n_predict, n_pc_inc, n_r_imm;
    logic        n_carry_en, n_flags_we, n_rf_we;
    logic [15:0] n_imm;
    logic [2:0]  n_mode, n_l_sel, n_r_sel, n_w_sel;
    logic [4:0]  n_jump_code;

    integer     seed;
    string      test_name;
    logic [2:0] dbg_ptr;
    jump_code_t jump_list [10] = '{JC_UNCOND, JC_CARRY, JC_EQUAL, JC_LT, JC_GT,
                                   JC_LE, JC_GE, JC_NE, JC_OVF, JC_PAR};

    `include "exec_tb_model.svh"

    exec_stage dut0 (.*);

    always #2 i_clk = ~i_clk;

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch in test %s", test_name);
        end
    endtask

    // Valid random instruction without a jump
    task automatic make_instr();
        n_submit    = 1'b1;
        n_flush     = 1'b0;
        n_imm       = $random(seed);
        n_predict   = $random(seed);
        n_pc_inc    = $random(seed);
        n_r_imm     = $random(seed);
        n_mode      = $random(seed);
        n_carry_en  = $random(seed);
        n_flags_we  = $random(seed);
        n_l_sel     = $random(seed);
        n_r_sel     = $random(seed);
        n_w_sel     = $random(seed);
        n_rf_we     = ($random(seed) & 7) != 0;
        n_jump_code = $random(seed) & 5'h0f;
    endtask

    task automatic drive_inputs();
        i_submit      <= n_submit;
        i_flush       <= n_flush;
        i_imm         <= n_imm;
        i_jmp_predict <= n_predict;
        i_pc_inc      <= n_pc_inc;
        i_r_imm       <= n_r_imm;
        i_alu_mode    <= alu_mode_t'(n_mode);
        i_carry_en    <= n_carry_en;
        i_flags_we    <= n_flags_we;
        i_l_sel       <= n_l_sel;
        i_r_sel       <= n_r_sel;
        i_w_sel       <= n_w_sel;
        i_rf_we       <= n_rf_we;
        i_jump_code   <= jump_code_t'(n_jump_code);
        i_dbg_sel     <= dbg_ptr;
    endtask

    // One instruction per cycle, state checked mid-cycle
    task automatic issue_instr();
        @(posedge i_clk);
        drive_inputs();
        @(negedge i_clk);
        check("pc", m_pc, o_exec_pc);
        check("flush", m_flush, o_flush);
        check("register", m_regs[dbg_ptr], o_dbg_reg);
        check("pc update", n_submit && !n_flush, o_pc_update);
        commit_instr();
        dbg_ptr = dbg_ptr + 3'd1;
    endtask

    // Bubbles while the debug port walks all registers
    task automatic idle_sweep();
        repeat (REGNO) begin
            make_instr();
            n_submit = 1'b0;
            issue_instr();
        end
    endtask

    initial begin
        seed    = 32'h7596_b968;
        dbg_ptr = '0;
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        make_instr();
        n_submit = 1'b0;
        drive_inputs();
        clear_state();
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        test_name = "reset";
        idle_sweep();

        test_name = "alu";
        repeat (400) begin
            make_instr();
            issue_instr();
        end
        idle_sweep();

        // Compare, then a jump that depends on the stored flags
        test_name = "flags";
        repeat (30) begin
            for (int c = 0; c < 10; c++) begin
                make_instr();
                n_mode  = ALU_SUB;
                n_rf_we = 1'b0;
                if (($random(seed) & 3) == 0) begin
                    n_r_imm = 1'b0;
                    n_r_sel = n_l_sel;
                end
                issue_instr();
                make_instr();
                n_mode      = ALU_PASS_R;
                n_r_imm     = 1'b1;
                n_rf_we     = 1'b0;
                n_flags_we  = 1'b0;
                n_jump_code = jump_list[c];
                issue_instr();
            end
        end

        test_name = "jump";
        repeat (300) begin
            make_instr();
            n_jump_code = $random(seed);
            issue_instr();
        end
        idle_sweep();

        test_name = "invalid";
        repeat (200) begin
            make_instr();
            n_submit    = $random(seed);
            n_flush     = $random(seed);
            n_jump_code = $random(seed);
            issue_instr();
        end
        idle_sweep();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
cpu_pkg.sv
exec_ctrl_if.sv
reg_file.sv
alu.sv
prog_counter.sv
exec_control.sv
exec_stage.sv
exec_stage_tb.sv
